// File: xaui_defs.svh
`ifndef XAUI_DEFS_SVH
`define XAUI_DEFS_SVH

// Lane count of the XAUI link.
`define XAUI_LANES 4

// Code-group sync thresholds per lane.
`define SYNC_GOOD_COMMAS 4
`define SYNC_BAD_CODES 4

// Lane alignment thresholds in /A/ events.
`define ALIGN_GOOD_COLS 4
`define ALIGN_BAD_COLS 4

// Transmit columns from one /A/ column to the next.
`define A_PERIOD 16

`endif

// File: xgmii_pkg.sv
package xgmii_pkg;

  // One XGMII transfer covering two 32-bit columns.
  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  ctrl;
  } xgmii_word_t;

  // Sequence ordered set, code byte in lane 0.
  typedef struct packed {
    logic [23:0] data;
    logic [7:0]  seq;
  } xgmii_os_t;

  // A column seen either as lane bytes or as an ordered set.
  typedef union packed {
    logic [3:0][7:0] lanes;
    xgmii_os_t       os;
  } xgmii_column_u;

  // Control codes.
  localparam logic [7:0] IDLE  = 8'h07;
  localparam logic [7:0] START = 8'hFB;
  localparam logic [7:0] TERM  = 8'hFD;
  localparam logic [7:0] ERROR = 8'hFE;
  localparam logic [7:0] SEQ   = 8'h9C;

  // Fault ordered-set payloads, lanes 3..1.
  localparam logic [23:0] LOCAL_FAULT_DATA  = 24'h01_0000;
  localparam logic [23:0] REMOTE_FAULT_DATA = 24'h02_0000;

endpackage

// File: mgt_pkg.sv
`include "xaui_defs.svh"

package mgt_pkg;

  // Transceiver word; byte k belongs to lane k mod 4.
  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  charisk;
  } mgt_word_t;

  // Per-byte receive flags from the transceiver.
  typedef struct packed {
    logic [7:0] codecomma;
    logic [7:0] codevalid;
  } mgt_lane_status_t;

  // Loopback sits in bit 0.
  typedef struct packed {
    logic [2:0] reserved;
    logic       reset_rx_link_status;
    logic       reset_local_fault;
    logic       powerdown;
    logic       loopback;
  } xaui_config_t;

  typedef struct packed {
    logic                   rx_link_up;
    logic                   align_status;
    logic [`XAUI_LANES-1:0] sync_status;
    logic [1:0]             local_fault;
  } xaui_status_t;

  // 8b/10b special characters.
  localparam logic [7:0] K28_5 = 8'hBC;
  localparam logic [7:0] K28_3 = 8'h7C;
  localparam logic [7:0] K28_4 = 8'h9C;

endpackage

// File: pcs_tx.sv
`timescale 1ns/1ps
`include "xaui_defs.svh"

module pcs_tx (
  input  logic                   usrclk,
  input  logic                   reset,
  input  xgmii_pkg::xgmii_word_t xgmii_tx,
  output mgt_pkg::mgt_word_t     mgt_tx
);

  localparam int CW = $clog2(`A_PERIOD);

  xgmii_pkg::xgmii_word_t tx_q;
  mgt_pkg::mgt_word_t     enc;
  logic [CW-1:0]          col;
  logic                   a_lo;
  logic                   a_hi;

  // Returns {charisk, code group} for one XGMII byte.
  function automatic logic [8:0] encode_byte(input logic [7:0] d, input logic c,
                                             input logic is_a);
    logic [8:0] r;
    if (!c) begin
      r = {1'b0, d};
    end else begin
      case (d)
        xgmii_pkg::IDLE:  r = {1'b1, is_a ? mgt_pkg::K28_3 : mgt_pkg::K28_5};
        xgmii_pkg::SEQ:   r = {1'b1, mgt_pkg::K28_4};
        xgmii_pkg::START,
        xgmii_pkg::TERM,
        xgmii_pkg::ERROR: r = {1'b1, d};
        default:          r = {1'b1, xgmii_pkg::ERROR};
      endcase
    end
    return r;
  endfunction

  always_ff @(posedge usrclk) begin
    tx_q <= xgmii_tx;
  end

  // Column number of the low half, modulo the /A/ period.
  always_ff @(posedge usrclk) begin
    if (reset) begin
      col <= '0;
    end else if (int'(col) + 2 >= `A_PERIOD) begin
      col <= CW'(int'(col) + 2 - `A_PERIOD);
    end else begin
      col <= col + CW'(2);
    end
  end

  assign a_lo = (col == '0);
  assign a_hi = (int'(col) + 1 == `A_PERIOD);

  always_comb begin
    for (int i = 0; i < 2 * `XAUI_LANES; i++) begin
      {enc.charisk[i], enc.data[8*i +: 8]} =
        encode_byte(tx_q.data[8*i +: 8], tx_q.ctrl[i], (i < `XAUI_LANES) ? a_lo : a_hi);
    end
  end

  always_ff @(posedge usrclk) begin
    if (reset) begin
      mgt_tx.data    <= {8{mgt_pkg::K28_5}};
      mgt_tx.charisk <= '1;
    end else begin
      mgt_tx <= enc;
    end
  end

endmodule

// File: pcs_sync.sv
`timescale 1ns/1ps
`include "xaui_defs.svh"

module pcs_sync (
  input  logic                      usrclk,
  input  logic                      reset,
  input  mgt_pkg::mgt_lane_status_t lane_status,
  input  logic [`XAUI_LANES-1:0]    syncok,
  input  logic [`XAUI_LANES-1:0]    rxlock,
  input  logic [`XAUI_LANES-1:0]    signal_detect,
  output logic [`XAUI_LANES-1:0]    lanesync,
  output logic [`XAUI_LANES-1:0]    enable_align
);

  localparam int N  = `XAUI_LANES;
  localparam int GW = $clog2(`SYNC_GOOD_COMMAS + 1);
  localparam int BW = $clog2(`SYNC_BAD_CODES + 1);

  logic [N-1:0]         comma;
  logic [N-1:0]         invalid;
  logic [N-1:0]         link_ok;
  logic [N-1:0]         sync_q;
  logic [N-1:0][GW-1:0] good_cnt;
  logic [N-1:0][BW-1:0] bad_cnt;

  // Each lane owns bytes k and k+N.
  always_comb begin
    for (int k = 0; k < N; k++) begin
      comma[k]   = lane_status.codecomma[k] | lane_status.codecomma[k+N];
      invalid[k] = ~(lane_status.codevalid[k] & lane_status.codevalid[k+N]);
      link_ok[k] = signal_detect[k] & rxlock[k] & syncok[k];
    end
  end

  always_ff @(posedge usrclk) begin
    if (reset) begin
      sync_q   <= '0;
      good_cnt <= '0;
      bad_cnt  <= '0;
    end else begin
      for (int k = 0; k < N; k++) begin
        if (!link_ok[k]) begin
          sync_q[k]   <= 1'b0;
          good_cnt[k] <= '0;
          bad_cnt[k]  <= '0;
        end else if (!sync_q[k]) begin
          // Hunting for consecutive clean commas.
          bad_cnt[k] <= '0;
          if (comma[k] && !invalid[k]) begin
            if (good_cnt[k] == GW'(`SYNC_GOOD_COMMAS - 1)) begin
              sync_q[k]   <= 1'b1;
              good_cnt[k] <= '0;
            end else begin
              good_cnt[k] <= good_cnt[k] + 1'b1;
            end
          end else begin
            good_cnt[k] <= '0;
          end
        end else begin
          good_cnt[k] <= '0;
          if (invalid[k]) begin
            if (bad_cnt[k] == BW'(`SYNC_BAD_CODES - 1)) begin
              sync_q[k]  <= 1'b0;
              bad_cnt[k] <= '0;
            end else begin
              bad_cnt[k] <= bad_cnt[k] + 1'b1;
            end
          end else begin
            bad_cnt[k] <= '0;
          end
        end
      end
    end
  end

  assign lanesync     = sync_q & link_ok;
  assign enable_align = ~lanesync;

endmodule

// File: pcs_deskew.sv
`timescale 1ns/1ps
`include "xaui_defs.svh"

module pcs_deskew (
  input  logic                   usrclk,
  input  logic                   reset,
  input  mgt_pkg::mgt_word_t     mgt_rx,
  input  logic [7:0]             codevalid,
  input  logic [`XAUI_LANES-1:0] sync_status,
  output logic                   enchansync,
  output logic                   align_status
);

  localparam int N  = `XAUI_LANES;
  localparam int GW = $clog2(`ALIGN_GOOD_COLS + 1);
  localparam int BW = $clog2(`ALIGN_BAD_COLS + 1);

  logic [1:0]    has_a;
  logic [1:0]    col_ok;
  logic [GW-1:0] good_cnt;
  logic [GW-1:0] good_n;
  logic [BW-1:0] bad_cnt;
  logic [BW-1:0] bad_n;
  logic          align_q;
  logic          align_n;

  // Low and high column of the word.
  always_comb begin
    for (int h = 0; h < 2; h++) begin
      has_a[h]  = 1'b0;
      col_ok[h] = 1'b1;
      for (int k = 0; k < N; k++) begin
        has_a[h]  |= mgt_rx.charisk[h*N+k] && (mgt_rx.data[8*(h*N+k) +: 8] == mgt_pkg::K28_3);
        col_ok[h] &= mgt_rx.charisk[h*N+k] && (mgt_rx.data[8*(h*N+k) +: 8] == mgt_pkg::K28_3)
                     && codevalid[h*N+k];
      end
    end
  end

  // Both columns are taken in order within one cycle.
  always_comb begin
    good_n  = good_cnt;
    bad_n   = bad_cnt;
    align_n = align_q;
    for (int h = 0; h < 2; h++) begin
      if (has_a[h]) begin
        if (!align_n) begin
          if (col_ok[h]) begin
            if (good_n == GW'(`ALIGN_GOOD_COLS - 1)) begin
              align_n = 1'b1;
              good_n  = '0;
            end else begin
              good_n = good_n + 1'b1;
            end
          end
        end else if (col_ok[h]) begin
          bad_n = '0;
        end else if (bad_n == BW'(`ALIGN_BAD_COLS - 1)) begin
          align_n = 1'b0;
          bad_n   = '0;
        end else begin
          bad_n = bad_n + 1'b1;
        end
      end
    end
    if (!(&sync_status)) begin
      align_n = 1'b0;
      good_n  = '0;
      bad_n   = '0;
    end
  end

  always_ff @(posedge usrclk) begin
    if (reset) begin
      align_q  <= 1'b0;
      good_cnt <= '0;
      bad_cnt  <= '0;
    end else begin
      align_q  <= align_n;
      good_cnt <= good_n;
      bad_cnt  <= bad_n;
    end
  end

  assign enchansync   = &sync_status;
  assign align_status = align_q;

endmodule

// File: pcs_rx.sv
`timescale 1ns/1ps
`include "xaui_defs.svh"

module pcs_rx (
  input  logic                   usrclk,
  input  logic                   reset,
  input  mgt_pkg::mgt_word_t     mgt_rx,
  input  logic [7:0]             codevalid,
  input  logic                   align_status,
  output xgmii_pkg::xgmii_word_t xgmii_rx
);

  mgt_pkg::mgt_word_t             rx_q;
  logic [7:0]                     valid_q;
  xgmii_pkg::xgmii_column_u [1:0] dec_col;
  logic [7:0]                     dec_ctrl;
  xgmii_pkg::xgmii_column_u       lf_col;

  always_ff @(posedge usrclk) begin
    rx_q    <= mgt_rx;
    valid_q <= codevalid;
  end

  always_comb begin
    for (int i = 0; i < 2 * `XAUI_LANES; i++) begin
      if (!valid_q[i]) begin
        dec_col[i / `XAUI_LANES].lanes[i % `XAUI_LANES] = xgmii_pkg::ERROR;
        dec_ctrl[i] = 1'b1;
      end else if (rx_q.charisk[i] && (rx_q.data[8*i +: 8] == mgt_pkg::K28_5 ||
                                       rx_q.data[8*i +: 8] == mgt_pkg::K28_3)) begin
        // Both /K/ and /A/ are idle.
        dec_col[i / `XAUI_LANES].lanes[i % `XAUI_LANES] = xgmii_pkg::IDLE;
        dec_ctrl[i] = 1'b1;
      end else begin
        dec_col[i / `XAUI_LANES].lanes[i % `XAUI_LANES] = rx_q.data[8*i +: 8];
        dec_ctrl[i] = rx_q.charisk[i];
      end
    end
  end

  // Local fault sequence column.
  always_comb begin
    lf_col.os.seq  = xgmii_pkg::SEQ;
    lf_col.os.data = xgmii_pkg::LOCAL_FAULT_DATA;
  end

  always_ff @(posedge usrclk) begin
    if (reset || !align_status) begin
      xgmii_rx.data <= {lf_col, lf_col};
      xgmii_rx.ctrl <= 8'h11;
    end else begin
      xgmii_rx.data <= dec_col;
      xgmii_rx.ctrl <= dec_ctrl;
    end
  end

endmodule

// File: xaui_status.sv
`timescale 1ns/1ps
`include "xaui_defs.svh"

module xaui_status (
  input  logic                   usrclk,
  input  logic                   reset,
  input  mgt_pkg::xaui_config_t  config_vector,
  input  logic [`XAUI_LANES-1:0] lanesync_int,
  input  logic                   align_int,
  input  xgmii_pkg::xgmii_word_t xgmii_rx,
  output logic                   loopback,
  output logic                   powerdown,
  output logic [`XAUI_LANES-1:0] sync_status,
  output logic                   align_status,
  output mgt_pkg::xaui_status_t  status_vector
);

  xgmii_pkg::xgmii_column_u [1:0] rx_cols;
  logic                           remote_fault;
  logic                           prev_reset_lf;
  logic                           prev_reset_link;
  logic [1:0]                     local_fault;
  logic                           rx_link_up;

  assign loopback  = config_vector.loopback;
  assign powerdown = config_vector.powerdown;

  assign rx_cols = xgmii_rx.data;

  // Remote fault ordered set in either column.
  always_comb begin
    remote_fault = 1'b0;
    for (int c = 0; c < 2; c++) begin
      remote_fault |= (xgmii_rx.ctrl[4*c +: 4] == 4'b0001) &&
                      (rx_cols[c].os.seq == xgmii_pkg::SEQ) &&
                      (rx_cols[c].os.data == xgmii_pkg::REMOTE_FAULT_DATA);
    end
  end

  always_ff @(posedge usrclk) begin
    if (reset) begin
      sync_status     <= '0;
      align_status    <= 1'b0;
      prev_reset_lf   <= 1'b0;
      prev_reset_link <= 1'b0;
      local_fault     <= 2'b10;
      rx_link_up      <= 1'b0;
    end else begin
      sync_status     <= lanesync_int;
      align_status    <= align_int;
      prev_reset_lf   <= config_vector.reset_local_fault;
      prev_reset_link <= config_vector.reset_rx_link_status;
      if (config_vector.reset_local_fault && !prev_reset_lf) begin
        local_fault <= 2'b00;
      end
      if (config_vector.reset_rx_link_status && !prev_reset_link) begin
        rx_link_up <= align_status;
      end
      if (remote_fault) begin
        local_fault[0] <= 1'b0;
      end
      // Loss of alignment wins over the clears above.
      if (!align_status) begin
        local_fault[1] <= 1'b1;
        rx_link_up     <= 1'b0;
      end
    end
  end

  always_comb begin
    status_vector.rx_link_up   = rx_link_up;
    status_vector.align_status = align_status;
    status_vector.sync_status  = sync_status;
    status_vector.local_fault  = local_fault;
  end

endmodule

// File: xaui_kat.sv
`timescale 1ns/1ps
`include "xaui_defs.svh"

module xaui_kat (
  input  logic                      usrclk,
  input  logic                      reset,
  input  xgmii_pkg::xgmii_word_t    xgmii_tx,
  output xgmii_pkg::xgmii_word_t    xgmii_rx,
  output mgt_pkg::mgt_word_t        mgt_tx,
  input  mgt_pkg::mgt_word_t        mgt_rx,
  input  mgt_pkg::mgt_lane_status_t mgt_lane,
  input  logic [`XAUI_LANES-1:0]    mgt_syncok,
  input  logic [`XAUI_LANES-1:0]    mgt_rxlock,
  input  logic [`XAUI_LANES-1:0]    signal_detect,
  output logic [`XAUI_LANES-1:0]    mgt_enable_align,
  output logic                      mgt_enchansync,
  output logic                      mgt_loopback,
  output logic                      mgt_powerdown,
  input  mgt_pkg::xaui_config_t     config_vector,
  output mgt_pkg::xaui_status_t     status_vector,
  output logic [`XAUI_LANES-1:0]    sync_status,
  output logic                      align_status
);

  // Unregistered status from the PCS blocks.
  logic [`XAUI_LANES-1:0] lanesync_int;
  logic                   align_int;

  pcs_tx pcs_tx_inst (
    .usrclk   (usrclk),
    .reset    (reset),
    .xgmii_tx (xgmii_tx),
    .mgt_tx   (mgt_tx)
  );

  pcs_sync pcs_sync_inst (
    .usrclk        (usrclk),
    .reset         (reset),
    .lane_status   (mgt_lane),
    .syncok        (mgt_syncok),
    .rxlock        (mgt_rxlock),
    .signal_detect (signal_detect),
    .lanesync      (lanesync_int),
    .enable_align  (mgt_enable_align)
  );

  pcs_deskew pcs_deskew_inst (
    .usrclk       (usrclk),
    .reset        (reset),
    .mgt_rx       (mgt_rx),
    .codevalid    (mgt_lane.codevalid),
    .sync_status  (sync_status),
    .enchansync   (mgt_enchansync),
    .align_status (align_int)
  );

  pcs_rx pcs_rx_inst (
    .usrclk       (usrclk),
    .reset        (reset),
    .mgt_rx       (mgt_rx),
    .codevalid    (mgt_lane.codevalid),
    .align_status (align_status),
    .xgmii_rx     (xgmii_rx)
  );

  xaui_status xaui_status_inst (
    .usrclk        (usrclk),
    .reset         (reset),
    .config_vector (config_vector),
    .lanesync_int  (lanesync_int),
    .align_int     (align_int),
    .xgmii_rx      (xgmii_rx),
    .loopback      (mgt_loopback),
    .powerdown     (mgt_powerdown),
    .sync_status   (sync_status),
    .align_status  (align_status),
    .status_vector (status_vector)
  );

endmodule

// File: tb_xaui_kat.sv
`timescale 1ns/1ps
`include "xaui_defs.svh"

module tb_xaui_kat;

  localparam int N            = `XAUI_LANES;
  localparam int RESET_CYCLES = 16;
  localparam int SYNC_CYCLES  = 300;
  localparam int ALIGN_CYCLES = 300;
  localparam int RX_CYCLES    = 300;
  localparam int STAT_CYCLES  = 400;
  localparam int SYNC_END     = RESET_CYCLES + SYNC_CYCLES;
  localparam int ALIGN_END    = SYNC_END + ALIGN_CYCLES;
  localparam int RX_END       = ALIGN_END + RX_CYCLES;
  localparam int TOTAL_CYCLES = RX_END + STAT_CYCLES;
  localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 200) * 40;
  // Local fault ordered set in both columns.
  localparam logic [63:0] LF_DATA = 64'h0100009C_0100009C;

  logic                      usrclk;
  logic                      reset;
  xgmii_pkg::xgmii_word_t    xgmii_tx;
  xgmii_pkg::xgmii_word_t    xgmii_rx;
  mgt_pkg::mgt_word_t        mgt_tx;
  mgt_pkg::mgt_word_t        mgt_rx;
  mgt_pkg::mgt_lane_status_t mgt_lane;
  logic [N-1:0]              mgt_syncok;
  logic [N-1:0]              mgt_rxlock;
  logic [N-1:0]              signal_detect;
  logic [N-1:0]              mgt_enable_align;
  logic                      mgt_enchansync;
  logic                      mgt_loopback;
  logic                      mgt_powerdown;
  mgt_pkg::xaui_config_t     config_vector;
  mgt_pkg::xaui_status_t     status_vector;
  logic [N-1:0]              sync_status;
  logic                      align_status;

  // Reference model state.
  xgmii_pkg::xgmii_word_t m_tx_q;
  mgt_pkg::mgt_word_t     m_mgt_tx;
  int                     tx_col;
  logic [N-1:0]           m_sync_q;
  logic [N-1:0]           m_lanesync;
  int                     sync_good [N];
  int                     sync_bad [N];
  logic                   m_align_q;
  int                     align_good;
  int                     align_bad;
  mgt_pkg::mgt_word_t     m_rx_q;
  logic [7:0]             m_valid_q;
  xgmii_pkg::xgmii_word_t m_xgmii_rx;
  mgt_pkg::xaui_status_t  m_status;
  logic                   m_prev_lf;
  logic                   m_prev_link;

  logic [15:0] lfsr;
  int          lane_mode [N];
  int          phase;
  int          pc;
  int          err_mgt;
  int          err_xgmii;
  int          err_status;
  int          err_lines;

  xaui_kat xaui_kat_inst (
    .usrclk           (usrclk),
    .reset            (reset),
    .xgmii_tx         (xgmii_tx),
    .xgmii_rx         (xgmii_rx),
    .mgt_tx           (mgt_tx),
    .mgt_rx           (mgt_rx),
    .mgt_lane         (mgt_lane),
    .mgt_syncok       (mgt_syncok),
    .mgt_rxlock       (mgt_rxlock),
    .signal_detect    (signal_detect),
    .mgt_enable_align (mgt_enable_align),
    .mgt_enchansync   (mgt_enchansync),
    .mgt_loopback     (mgt_loopback),
    .mgt_powerdown    (mgt_powerdown),
    .config_vector    (config_vector),
    .status_vector    (status_vector),
    .sync_status      (sync_status),
    .align_status     (align_status)
  );

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit.
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[62:0], fb};
    end
    return r;
  endfunction

  // Expected {charisk, code group} for one transmit byte.
  function automatic logic [8:0] tx_code(input logic [7:0] d, input logic c, input logic a_col);
    if (!c) begin
      return {1'b0, d};
    end
    if (d == xgmii_pkg::IDLE) begin
      return {1'b1, a_col ? mgt_pkg::K28_3 : mgt_pkg::K28_5};
    end
    if (d == xgmii_pkg::START || d == xgmii_pkg::TERM || d == xgmii_pkg::SEQ ||
        d == xgmii_pkg::ERROR) begin
      return {1'b1, d};
    end
    return {1'b1, xgmii_pkg::ERROR};
  endfunction

  // Expected {control, byte} for one received code group.
  function automatic logic [8:0] rx_code(input logic [7:0] d, input logic k, input logic v);
    if (!v) begin
      return {1'b1, xgmii_pkg::ERROR};
    end
    if (k && (d == mgt_pkg::K28_5 || d == mgt_pkg::K28_3)) begin
      return {1'b1, xgmii_pkg::IDLE};
    end
    return {k, d};
  endfunction

  function automatic logic is_remote_fault(input logic [31:0] col, input logic [3:0] ctrl);
    return ctrl == 4'b0001 && col[7:0] == xgmii_pkg::SEQ &&
           col[31:8] == xgmii_pkg::REMOTE_FAULT_DATA;
  endfunction

  // Puts K28_3 on the chosen lanes of one column.
  task automatic put_a(inout mgt_pkg::mgt_word_t w, input int h, input logic [3:0] which);
    for (int k = 0; k < N; k++) begin
      if (which[k]) begin
        w.data[8*(h*N+k) +: 8] = mgt_pkg::K28_3;
        w.charisk[h*N+k]       = 1'b1;
      end
    end
  endtask

  // Advances the model over one rising edge with the inputs now applied.
  task automatic model_step();
    logic [N-1:0]           link_ok;
    logic [N-1:0]           ls_now;
    logic [1:0]             a_seen;
    logic [1:0]             a_ok;
    logic [8:0]             code;
    logic                   comma;
    logic                   bad_code;
    logic                   is_a;
    logic                   rf;
    mgt_pkg::xaui_status_t  st;
    xgmii_pkg::xgmii_word_t rx_next;

    for (int k = 0; k < N; k++) begin
      link_ok[k] = signal_detect[k] & mgt_rxlock[k] & mgt_syncok[k];
    end
    ls_now = m_sync_q & link_ok;

    rf = is_remote_fault(m_xgmii_rx.data[31:0], m_xgmii_rx.ctrl[3:0]) ||
         is_remote_fault(m_xgmii_rx.data[63:32], m_xgmii_rx.ctrl[7:4]);
    st = m_status;
    if (reset) begin
      st             = '0;
      st.local_fault = 2'b10;
    end else begin
      st.sync_status  = ls_now;
      st.align_status = m_align_q;
      if (config_vector.reset_local_fault && !m_prev_lf) begin
        st.local_fault = 2'b00;
      end
      if (config_vector.reset_rx_link_status && !m_prev_link) begin
        st.rx_link_up = m_status.align_status;
      end
      if (rf) begin
        st.local_fault[0] = 1'b0;
      end
      if (!m_status.align_status) begin
        st.local_fault[1] = 1'b1;
        st.rx_link_up     = 1'b0;
      end
    end
    m_prev_lf   = !reset && config_vector.reset_local_fault;
    m_prev_link = !reset && config_vector.reset_rx_link_status;

    if (reset || !m_status.align_status) begin
      rx_next.data = LF_DATA;
      rx_next.ctrl = 8'h11;
    end else begin
      for (int i = 0; i < 2 * N; i++) begin
        code                   = rx_code(m_rx_q.data[8*i +: 8], m_rx_q.charisk[i], m_valid_q[i]);
        rx_next.ctrl[i]        = code[8];
        rx_next.data[8*i +: 8] = code[7:0];
      end
    end
    m_rx_q    = mgt_rx;
    m_valid_q = mgt_lane.codevalid;

    // /A/ events, low column first.
    for (int h = 0; h < 2; h++) begin
      a_seen[h] = 1'b0;
      a_ok[h]   = 1'b1;
      for (int k = 0; k < N; k++) begin
        is_a      = mgt_rx.charisk[h*N+k] && mgt_rx.data[8*(h*N+k) +: 8] == mgt_pkg::K28_3;
        a_seen[h] = a_seen[h] | is_a;
        a_ok[h]   = a_ok[h] & is_a & mgt_lane.codevalid[h*N+k];
      end
      if (a_seen[h] && !m_align_q) begin
        if (a_ok[h]) begin
          align_good++;
          if (align_good == `ALIGN_GOOD_COLS) begin
            m_align_q  = 1'b1;
            align_good = 0;
          end
        end
      end else if (a_seen[h]) begin
        if (a_ok[h]) begin
          align_bad = 0;
        end else begin
          align_bad++;
          if (align_bad == `ALIGN_BAD_COLS) begin
            m_align_q = 1'b0;
            align_bad = 0;
          end
        end
      end
    end
    if (reset || !(&m_status.sync_status)) begin
      m_align_q  = 1'b0;
      align_good = 0;
      align_bad  = 0;
    end

    for (int k = 0; k < N; k++) begin
      comma    = mgt_lane.codecomma[k] | mgt_lane.codecomma[k+N];
      bad_code = !(mgt_lane.codevalid[k] & mgt_lane.codevalid[k+N]);
      if (reset || !link_ok[k]) begin
        m_sync_q[k]  = 1'b0;
        sync_good[k] = 0;
        sync_bad[k]  = 0;
      end else if (!m_sync_q[k]) begin
        sync_bad[k]  = 0;
        sync_good[k] = (comma && !bad_code) ? sync_good[k] + 1 : 0;
        if (sync_good[k] == `SYNC_GOOD_COMMAS) begin
          m_sync_q[k]  = 1'b1;
          sync_good[k] = 0;
        end
      end else begin
        sync_good[k] = 0;
        sync_bad[k]  = bad_code ? sync_bad[k] + 1 : 0;
        if (sync_bad[k] == `SYNC_BAD_CODES) begin
          m_sync_q[k] = 1'b0;
          sync_bad[k] = 0;
        end
      end
    end

    if (reset) begin
      m_mgt_tx.data    = {8{mgt_pkg::K28_5}};
      m_mgt_tx.charisk = '1;
    end else begin
      for (int i = 0; i < 2 * N; i++) begin
        code = tx_code(m_tx_q.data[8*i +: 8], m_tx_q.ctrl[i],
                       (i < N) ? (tx_col % `A_PERIOD == 0) : ((tx_col + 1) % `A_PERIOD == 0));
        m_mgt_tx.charisk[i]     = code[8];
        m_mgt_tx.data[8*i +: 8] = code[7:0];
      end
    end
    m_tx_q = xgmii_tx;
    tx_col = reset ? 0 : tx_col + 2;

    m_status   = st;
    m_xgmii_rx = rx_next;
    m_lanesync = m_sync_q & link_ok;
  endtask

  task automatic check_mgt(input mgt_pkg::mgt_word_t got, input mgt_pkg::mgt_word_t exp);
    if (got !== exp) begin
      err_mgt++;
      $display("Mismatch at %0t ns: mgt_tx got %h/%h expected %h/%h", $time,
               got.data, got.charisk, exp.data, exp.charisk);
    end
  endtask

  task automatic check_xgmii(input xgmii_pkg::xgmii_word_t got,
                             input xgmii_pkg::xgmii_word_t exp);
    if (got !== exp) begin
      err_xgmii++;
      $display("Mismatch at %0t ns: xgmii_rx got %h/%h expected %h/%h", $time,
               got.data, got.ctrl, exp.data, exp.ctrl);
    end
  endtask

  task automatic check_status(input mgt_pkg::xaui_status_t got, input mgt_pkg::xaui_status_t exp);
    if (got !== exp) begin
      err_status++;
      $display("Mismatch at %0t ns: status_vector got %b expected %b", $time, got, exp);
    end
  endtask

  // enable_align, sync_status, align_status, enchansync, loopback, powerdown.
  task automatic check_lines(input logic [11:0] got, input logic [11:0] exp);
    if (got !== exp) begin
      err_lines++;
      $display("Mismatch at %0t ns: control lines got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic check_all();
    check_mgt(mgt_tx, m_mgt_tx);
    check_xgmii(xgmii_rx, m_xgmii_rx);
    check_status(status_vector, m_status);
    check_lines({mgt_enable_align, sync_status, align_status, mgt_enchansync,
                 mgt_loopback, mgt_powerdown},
                {~m_lanesync, m_status.sync_status, m_status.align_status,
                 &m_status.sync_status, config_vector.loopback, config_vector.powerdown});
  endtask

  task automatic drive_inputs(input int ph, input int cyc);
    logic [2:0]                sel;
    xgmii_pkg::xgmii_word_t    tx;
    mgt_pkg::mgt_word_t        rx;
    mgt_pkg::mgt_lane_status_t ls;
    logic [N-1:0]              sd;
    logic [N-1:0]              lock;
    logic [N-1:0]              sok;
    mgt_pkg::xaui_config_t     cfg;

    for (int i = 0; i < 2 * N; i++) begin
      sel = 3'(rand_bits(3));
      tx.ctrl[i] = (sel > 3'd2);
      case (sel)
        3'd0, 3'd1, 3'd2: tx.data[8*i +: 8] = 8'(rand_bits(8));
        3'd3, 3'd4:       tx.data[8*i +: 8] = xgmii_pkg::IDLE;
        3'd5:             tx.data[8*i +: 8] = xgmii_pkg::START;
        3'd6:             tx.data[8*i +: 8] = xgmii_pkg::TERM;
        default: begin
          if (rand_bits(1) != 0) begin
            tx.data[8*i +: 8] = (rand_bits(1) != 0) ? xgmii_pkg::SEQ : xgmii_pkg::ERROR;
          end else begin
            tx.data[8*i +: 8] = 8'(rand_bits(8));
          end
        end
      endcase
    end

    cfg           = config_vector;
    cfg.reserved  = '0;
    cfg.loopback  = 1'(rand_bits(1));
    cfg.powerdown = 1'(rand_bits(1));
    rx.data       = {8{mgt_pkg::K28_5}};
    rx.charisk    = '1;
    ls.codecomma  = '1;
    ls.codevalid  = '1;
    sd            = '1;
    lock          = '1;
    sok           = '1;

    if (ph == 1) begin
      // Each lane holds a clean, broken or noisy mode for eight cycles.
      rx.data    = rand_bits(64);
      rx.charisk = 8'(rand_bits(8));
      for (int k = 0; k < N; k++) begin
        if (cyc % 8 == 0) begin
          lane_mode[k] = int'(rand_bits(2));
        end
        ls.codecomma[k]   = 1'(rand_bits(1));
        ls.codecomma[k+N] = 1'(rand_bits(1));
        case (lane_mode[k])
          0: ls.codevalid[k] = 1'b0;
          1: ls.codevalid[k+N] = 1'(rand_bits(1));
          default: ls.codecomma[k] = 1'b1;
        endcase
        if (rand_bits(5) == 0) begin
          sd[k] = 1'b0;
        end
        if (rand_bits(6) == 0) begin
          lock[k] = 1'b0;
        end
        if (rand_bits(6) == 0) begin
          sok[k] = 1'b0;
        end
      end
    end else if (ph == 2) begin
      for (int i = 0; i < 2 * N; i++) begin
        ls.codevalid[i] = (rand_bits(6) != 0);
      end
      sel = 3'(rand_bits(3));
      case (sel)
        3'd0: put_a(rx, 0, 4'hF);
        3'd1: put_a(rx, 1, 4'hF);
        3'd2: put_a(rx, 0, 4'(rand_bits(4)));
        3'd3: begin
          put_a(rx, 0, 4'hF);
          put_a(rx, 1, 4'hF);
        end
        default: ;
      endcase
    end else if (ph >= 3) begin
      rx.data = rand_bits(64);
      for (int i = 0; i < 2 * N; i++) begin
        rx.charisk[i]   = (rand_bits(2) == 0);
        ls.codevalid[i] = (rand_bits(6) != 0);
        if (rand_bits(3) == 0) begin
          rx.data[8*i +: 8] = mgt_pkg::K28_5;
          rx.charisk[i]     = 1'b1;
        end
      end
      if (cyc % 8 == 0) begin
        put_a(rx, 0, 4'hF);
      end
      if (ph == 4) begin
        if (cyc % 8 == 4 && rand_bits(1) != 0) begin
          rx.data[31:0]      = {xgmii_pkg::REMOTE_FAULT_DATA, mgt_pkg::K28_4};
          rx.charisk[3:0]    = 4'b0001;
          ls.codevalid[3:0]  = 4'hF;
        end
        if (rand_bits(3) == 0) begin
          cfg.reset_local_fault = ~cfg.reset_local_fault;
        end
        if (rand_bits(3) == 0) begin
          cfg.reset_rx_link_status = ~cfg.reset_rx_link_status;
        end
        // Lane 1 drops out briefly to force alignment loss.
        if (cyc % 128 >= 60 && cyc % 128 < 64) begin
          sd[1] = 1'b0;
        end
      end
    end

    xgmii_tx      = tx;
    mgt_rx        = rx;
    mgt_lane      = ls;
    signal_detect = sd;
    mgt_rxlock    = lock;
    mgt_syncok    = sok;
    config_vector = cfg;
  endtask

  initial begin
    usrclk = 1'b0;
    forever #20 usrclk = ~usrclk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

  initial begin
    lfsr          = 16'd31;
    err_mgt       = 0;
    err_xgmii     = 0;
    err_status    = 0;
    err_lines     = 0;
    reset         = 1'b1;
    xgmii_tx      = {{8{xgmii_pkg::IDLE}}, 8'hFF};
    mgt_rx        = {{8{mgt_pkg::K28_5}}, 8'hFF};
    mgt_lane      = {8'h00, 8'hFF};
    mgt_syncok    = '1;
    mgt_rxlock    = '1;
    signal_detect = '1;
    config_vector = '0;
    tx_col        = 0;
    m_sync_q      = '0;
    m_align_q     = 1'b0;
    m_status      = '0;
    m_xgmii_rx    = '0;
    m_prev_lf     = 1'b0;
    m_prev_link   = 1'b0;
    align_good    = 0;
    align_bad     = 0;
    for (int k = 0; k < N; k++) begin
      sync_good[k] = 0;
      sync_bad[k]  = 0;
      lane_mode[k] = 0;
    end
    model_step();

    for (int cyc = 0; cyc < TOTAL_CYCLES; cyc++) begin
      @(negedge usrclk);
      check_all();
      if (cyc < RESET_CYCLES) begin
        phase = 0;
        pc    = cyc;
      end else if (cyc < SYNC_END) begin
        phase = 1;
        pc    = cyc - RESET_CYCLES;
      end else if (cyc < ALIGN_END) begin
        phase = 2;
        pc    = cyc - SYNC_END;
      end else if (cyc < RX_END) begin
        phase = 3;
        pc    = cyc - ALIGN_END;
      end else begin
        phase = 4;
        pc    = cyc - RX_END;
      end
      reset = (cyc + 1 < RESET_CYCLES);
      drive_inputs(phase, pc);
      model_step();
    end
    @(negedge usrclk);
    check_all();

    $display("Errors: mgt_tx %0d, xgmii_rx %0d, status %0d, control lines %0d",
             err_mgt, err_xgmii, err_status, err_lines);
    if (err_mgt + err_xgmii + err_status + err_lines == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+.
xgmii_pkg.sv
mgt_pkg.sv
pcs_tx.sv
pcs_sync.sv
pcs_deskew.sv
pcs_rx.sv
xaui_status.sv
xaui_kat.sv
tb_xaui_kat.sv

// File: Bender.yml
package:
  name: xaui_kat

sources:
  - include_dirs:
      - .
    files:
      - xgmii_pkg.sv
      - mgt_pkg.sv
      - pcs_tx.sv
      - pcs_sync.sv
      - pcs_deskew.sv
      - pcs_rx.sv
      - xaui_status.sv
      - xaui_kat.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_xaui_kat.sv
